//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_sys_video -f sim.f
	@out=$$(./obj_dir/Vtb_sys_video); \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- sim.f
source/hps_io_pkg.sv
source/video_sync_pkg.sv
source/io_cmd_decoder.sv
source/sync_polarity_fix.sv
source/csync_gen.sv
source/sys_video_top.sv
verif/tb_sys_video.sv

//--- source/csync_gen.sv
`timescale 1ns/1ns
`default_nettype none

module csync_gen #(
	parameter int CNT_W = 16
) (
	input  wire                             clk_sys,
	input  wire                             resetd,
	input  wire video_sync_pkg::sync_pair_t i_sync,
	input  wire                             i_csync_en,
	output logic                            o_hsync_pin,
	output logic                            o_vsync_pin
);

	logic             hs_q;
	logic             hs_edge;
	logic [CNT_W-1:0] h_cnt;
	logic [CNT_W-1:0] space_len;
	logic [CNT_W-1:0] hs_len;
	logic [CNT_W-1:0] shift_pt;
	logic             shift_hs;
	logic             csync_vs;
	logic             csync;

	assign hs_edge = hs_q ^ i_sync.hs;

	// Shifted pulse starts one pulse width before the next hsync
	assign shift_pt = space_len - hs_len;

	//////////////////////////////
	// Line and pulse lengths
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hs_q      <= 1'b0;
			h_cnt     <= '0;
			space_len <= '0;
			hs_len    <= '0;
		end else begin
			hs_q <= i_sync.hs;
			if (hs_edge) begin
				h_cnt <= '0;
				// Low part of the line ends at the rising edge
				if (i_sync.hs) begin
					space_len <= h_cnt;
				end else begin
					hs_len <= h_cnt;
				end
			end else if (~&h_cnt) begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////
	// Composite sync
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			shift_hs <= 1'b0;
			csync_vs <= 1'b0;
		end else begin
			csync_vs <= i_sync.vs;
			if (!i_sync.vs) begin
				shift_hs <= i_sync.hs;
			end else if (h_cnt == shift_pt) begin
				shift_hs <= 1'b1;
			end else if (hs_edge && i_sync.hs) begin
				shift_hs <= 1'b0;
			end
		end
	end

	assign csync = csync_vs ^ shift_hs;

	// Output pins
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_hsync_pin <= 1'b0;
			o_vsync_pin <= 1'b0;
		end else begin
			o_hsync_pin <= i_csync_en ? csync : i_sync.hs;
			o_vsync_pin <= i_sync.vs & ~i_csync_en;
		end
	end

	a_csync_follows_hs: assert property (
		@(posedge clk_sys) disable iff (resetd)
		!$past(i_sync.vs) |-> (csync == $past(i_sync.hs))
	);

endmodule

`default_nettype wire

//--- source/hps_io_pkg.sv
`default_nettype none

package hps_io_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	// One host transfer word
	localparam int IO_WORD_W = 16;

	// Board LED bus
	localparam int LED_W = 8;

	typedef logic [IO_WORD_W-1:0] io_word_t;

	// Strobed host port, select frames a whole command
	typedef struct packed {
		logic     select;
		logic     strobe;
		io_word_t data;
	} io_bus_t;

	//////////////////////////////
	// Commands
	//////////////////////////////

	// Opcode sits in data[7:0] of the first word
	typedef enum logic [7:0] {
		CMD_CFG = 8'h01,
		CMD_LED = 8'h25
	} io_opcode_e;

	// Config word bit for composite sync
	localparam int CFG_CSYNC_BIT = 3;

	// LED word with the overtake mask in the upper byte
	typedef struct packed {
		logic [LED_W-1:0] overtake;
		logic [LED_W-1:0] state;
	} led_ctrl_t;

endpackage

`default_nettype wire

//--- source/io_cmd_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module io_cmd_decoder (
	input  wire                          clk_sys,
	input  wire                          resetd,
	input  wire hps_io_pkg::io_bus_t     i_io,
	input  wire [hps_io_pkg::LED_W-1:0]  i_status,
	output logic                         o_csync_en,
	output logic [hps_io_pkg::LED_W-1:0] o_led
);

	hps_io_pkg::io_bus_t    io_q;
	logic                   strobe_q;
	logic                   strobe_rise;
	logic                   cmd_pending;
	hps_io_pkg::io_opcode_e cmd_op;
	logic                   cfg_csync;
	hps_io_pkg::led_ctrl_t  led_ctrl;

	//////////////////////////////
	// Strobe edge detect
	//////////////////////////////

	// Host port sampled once and the strobe delayed again for the edge
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			io_q     <= '0;
			strobe_q <= 1'b0;
		end else begin
			io_q     <= i_io;
			strobe_q <= io_q.strobe;
		end
	end

	assign strobe_rise = io_q.select & io_q.strobe & ~strobe_q;

	//////////////////////////////
	// Command framing
	//////////////////////////////

	// First selected strobe carries the opcode
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			cmd_pending <= 1'b0;
			cmd_op      <= hps_io_pkg::io_opcode_e'(8'h00);
		end else if (!io_q.select) begin
			cmd_pending <= 1'b0;
		end else if (strobe_rise && !cmd_pending) begin
			cmd_pending <= 1'b1;
			cmd_op      <= hps_io_pkg::io_opcode_e'(io_q.data[7:0]);
		end
	end

	// Data words of the pending command
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			cfg_csync <= 1'b0;
			led_ctrl  <= '0;
		end else if (strobe_rise && cmd_pending) begin
			case (cmd_op)
				hps_io_pkg::CMD_CFG: begin
					cfg_csync <= io_q.data[hps_io_pkg::CFG_CSYNC_BIT];
				end
				hps_io_pkg::CMD_LED: begin
					led_ctrl <= hps_io_pkg::led_ctrl_t'(io_q.data);
				end
				// Unknown opcodes just swallow their words
				default: ;
			endcase
		end
	end

	//////////////////////////////
	// Outputs
	//////////////////////////////

	assign o_csync_en = cfg_csync;

	// Overtaken bits come from the host and the rest show status
	assign o_led = (led_ctrl.overtake & led_ctrl.state) |
		(~led_ctrl.overtake & i_status);

	// Select low on the port leaves no command pending two clocks on
	a_pending_cleared: assert property (
		@(posedge clk_sys) disable iff (resetd)
		!i_io.select |-> ##2 !cmd_pending
	);

endmodule

`default_nettype wire

//--- source/sync_polarity_fix.sv
`timescale 1ns/1ns
`default_nettype none

module sync_polarity_fix #(
	parameter int CNT_W = 16
) (
	input  wire  clk_sys,
	input  wire  resetd,
	input  wire  i_sync,
	output logic o_sync,
	output logic o_pol
);

	logic             s1;
	logic             s2;
	logic             edge_seen;
	logic [CNT_W-1:0] run_cnt;
	logic [CNT_W-1:0] high_len;
	logic [CNT_W-1:0] low_len;
	logic             pol;

	// Two stage sampler
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1 <= 1'b0;
			s2 <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;
		end
	end

	assign edge_seen = s1 ^ s2;

	//////////////////////////////
	// Run lengths
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			run_cnt  <= '0;
			high_len <= '0;
			low_len  <= '0;
		end else if (edge_seen) begin
			run_cnt <= '0;
			// Rising edge closes a low run
			if (s1) begin
				low_len <= run_cnt;
			end else begin
				high_len <= run_cnt;
			end
		end else if (~&run_cnt) begin
			run_cnt <= run_cnt + 1'b1;
		end
	end

	// Longer high phase means the pulse is active low
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			pol    <= 1'b0;
			o_sync <= 1'b0;
		end else begin
			pol    <= high_len > low_len;
			o_sync <= i_sync ^ pol;
		end
	end

	assign o_pol = pol;

	// Polarity moves two clocks after a sampled transition at most
	a_pol_after_edge: assert property (
		@(posedge clk_sys) disable iff (resetd)
		$changed(pol) |-> $past(edge_seen, 2)
	);

endmodule

`default_nettype wire

//--- source/sys_video_top.sv
`timescale 1ns/1ns
`default_nettype none

module sys_video_top #(
	parameter int CNT_W = 16
) (
	input  wire                             clk_sys,
	input  wire                             resetd,
	input  wire hps_io_pkg::io_bus_t        i_io,
	input  wire video_sync_pkg::sync_pair_t i_sync,
	output wire video_sync_pkg::sync_pair_t o_sync,
	output wire                             o_hsync_pin,
	output wire                             o_vsync_pin,
	output wire [hps_io_pkg::LED_W-1:0]     o_led
);

	logic [video_sync_pkg::SYNC_CHANNELS-1:0] sync_norm;
	logic [video_sync_pkg::SYNC_CHANNELS-1:0] sync_pol;
	logic                                     csync_en;
	logic [hps_io_pkg::LED_W-1:0]             led_status;

	//////////////////////////////
	// Host command port
	//////////////////////////////

	// Status shows detected polarity of H and V
	assign led_status = {
		{(hps_io_pkg::LED_W - 2){1'b0}},
		sync_pol[video_sync_pkg::SYNC_V],
		sync_pol[video_sync_pkg::SYNC_H]
	};

	io_cmd_decoder u_cmd (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_io       (i_io),
		.i_status   (led_status),
		.o_csync_en (csync_en),
		.o_led      (o_led)
	);

	//////////////////////////////
	// Sync normalisers
	//////////////////////////////

	for (genvar k = 0; k < video_sync_pkg::SYNC_CHANNELS; k++) begin : g_sync_fix
		sync_polarity_fix #(
			.CNT_W (CNT_W)
		) u_fix (
			.clk_sys (clk_sys),
			.resetd  (resetd),
			.i_sync  (i_sync[k]),
			.o_sync  (sync_norm[k]),
			.o_pol   (sync_pol[k])
		);
	end

	assign o_sync = '{
		hs: sync_norm[video_sync_pkg::SYNC_H],
		vs: sync_norm[video_sync_pkg::SYNC_V]
	};

	// Composite sync and pin select
	csync_gen #(
		.CNT_W (CNT_W)
	) u_csync (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_sync      (o_sync),
		.i_csync_en  (csync_en),
		.o_hsync_pin (o_hsync_pin),
		.o_vsync_pin (o_vsync_pin)
	);

endmodule

`default_nettype wire

//--- source/video_sync_pkg.sv
`default_nettype none

package video_sync_pkg;

	//////////////////////////////
	// Sync channels
	//////////////////////////////

	// Number of sync signals that get a polarity normaliser
	localparam int SYNC_CHANNELS = 2;

	// Loop index of each channel
	typedef enum logic [0:0] {
		SYNC_H = 1'b0,
		SYNC_V = 1'b1
	} sync_chan_e;

	//////////////////////////////
	// Sync pair
	//////////////////////////////

	// Bit k of the pair is channel k, so hs is the LSB
	typedef struct packed {
		logic vs;
		logic hs;
	} sync_pair_t;

endpackage

`default_nettype wire

//--- verif/tb_sys_video.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sys_video;

	localparam int CNT_W        = 16;
	localparam int CLK_PERIOD   = 4;
	localparam int FRAME_LINES  = 20;
	localparam int VS_LINES     = 3;
	localparam int HS_WIDTH     = 8;
	localparam int LINE_MAX     = 127;
	localparam int TOTAL_FRAMES = 20;
	localparam int WATCHDOG_NS  = TOTAL_FRAMES * FRAME_LINES * LINE_MAX * CLK_PERIOD * 2;

	logic                       clk_sys;
	logic                       resetd;
	hps_io_pkg::io_bus_t        i_io;
	video_sync_pkg::sync_pair_t i_sync;
	video_sync_pkg::sync_pair_t dut_sync;
	logic                       hsync_pin;
	logic                       vsync_pin;
	logic [7:0]                 led;

	// Stimulus state, written on the falling edge
	video_sync_pkg::sync_pair_t ideal;
	video_sync_pkg::sync_pair_t inv;
	logic                       video_on;
	int                         frame_cnt;
	logic [31:0]                line_lfsr;
	logic [31:0]                cmd_lfsr;
	logic                       chk_sync;
	logic                       chk_raw;
	logic                       chk_cs;

	// Copies taken on the rising edge for the compare process
	video_sync_pkg::sync_pair_t ideal_q;
	logic                       chk_sync_q;
	logic                       chk_raw_q;
	logic                       chk_cs_q;
	video_sync_pkg::sync_pair_t sync_d1;
	video_sync_pkg::sync_pair_t sync_d2;
	int                         vs_low_run;

	sys_video_top #(
		.CNT_W (CNT_W)
	) dut (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io        (i_io),
		.i_sync      (i_sync),
		.o_sync      (dut_sync),
		.o_hsync_pin (hsync_pin),
		.o_vsync_pin (vsync_pin),
		.o_led       (led)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] st);
		return st[0] ? ((st >> 1) ^ 32'h8020_0003) : (st >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic draw_bits(inout logic [31:0] st, input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val[i] = st[0];
			st = lfsr_next(st);
		end
	endtask

	function automatic logic [7:0] ref_led(input hps_io_pkg::led_ctrl_t ctrl,
		input video_sync_pkg::sync_pair_t pol);
		logic [7:0] status;
		status    = '0;
		status[0] = pol.hs;
		status[1] = pol.vs;
		return (ctrl.overtake & ctrl.state) | (~ctrl.overtake & status);
	endfunction

	// Pins as {vsync, hsync}; d1 and d2 are o_sync one and two clocks back
	function automatic logic [1:0] ref_pins(input video_sync_pkg::sync_pair_t d1,
		input video_sync_pkg::sync_pair_t d2, input logic csync_en);
		if (csync_en) begin
			return {1'b0, d2.hs};
		end
		return {d1.vs, d1.hs};
	endfunction

	task automatic check_value(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		assert (exp === act) else begin
			$display("FAILED %s expected %h actual %h", name, exp, act);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = frame_cnt + n;
		wait (frame_cnt >= target);
	endtask

	// Strobe high two clocks, low two clocks
	task automatic host_word(input hps_io_pkg::io_word_t w);
		@(negedge clk_sys);
		i_io.data   = w;
		i_io.strobe = 1'b1;
		repeat (2) @(negedge clk_sys);
		i_io.strobe = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic host_cmd(input logic [7:0] op, input int n,
		input hps_io_pkg::io_word_t w0, input hps_io_pkg::io_word_t w1);
		@(negedge clk_sys);
		i_io.select = 1'b1;
		host_word({8'h00, op});
		if (n > 0) begin
			host_word(w0);
		end
		if (n > 1) begin
			host_word(w1);
		end
		@(negedge clk_sys);
		i_io.select = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	//////////////////////////////
	// Video source
	//////////////////////////////

	initial begin : video_gen
		int          line_len;
		logic [15:0] bits;
		i_sync    = '0;
		ideal     = '0;
		frame_cnt = 0;
		line_lfsr = 32'h5e2b;
		wait (video_on);
		forever begin
			draw_bits(line_lfsr, 6, bits);
			line_len = 64 + int'(bits[5:0]);
			for (int line = 0; line < FRAME_LINES; line++) begin
				for (int col = 0; col < line_len; col++) begin
					@(negedge clk_sys);
					ideal.hs = (col < HS_WIDTH);
					ideal.vs = (line < VS_LINES);
					i_sync   = video_sync_pkg::sync_pair_t'(ideal ^ inv);
					if (line == 0 && col == 0) begin
						frame_cnt++;
					end
				end
			end
		end
	end

	//////////////////////////////
	// Compare
	//////////////////////////////

	always @(posedge clk_sys) begin
		ideal_q    <= ideal;
		chk_sync_q <= chk_sync;
		chk_raw_q  <= chk_raw;
		chk_cs_q   <= chk_cs;
	end

	always @(negedge clk_sys) begin : compare
		logic [1:0] exp_pins;
		exp_pins = ref_pins(sync_d1, sync_d2, chk_cs_q);
		if (chk_sync_q) begin
			check_value("sync_norm", 16'(ideal_q), 16'(dut_sync));
		end
		if (chk_raw_q) begin
			check_value("pins_raw", 16'(exp_pins), 16'({vsync_pin, hsync_pin}));
		end
		if (chk_cs_q) begin
			check_value("pins_csync_vs", 16'(exp_pins[1]), 16'(vsync_pin));
			// Only well clear of vsync
			if (vs_low_run >= LINE_MAX) begin
				check_value("pins_csync_hs", 16'(exp_pins[0]), 16'(hsync_pin));
			end
		end
		vs_low_run = dut_sync.vs ? 0 : vs_low_run + 1;
		sync_d2    = sync_d1;
		sync_d1    = dut_sync;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the test sequence finished");
		$display("Checks failed");
		$fatal(1);
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin : main
		hps_io_pkg::led_ctrl_t led_word;
		logic [15:0]           bits;
		i_io       = '0;
		resetd     = 1'b1;
		inv        = '0;
		video_on   = 1'b0;
		chk_sync   = 1'b0;
		chk_raw    = 1'b0;
		chk_cs     = 1'b0;
		vs_low_run = 0;
		sync_d1    = '0;
		sync_d2    = '0;
		cmd_lfsr   = 32'h5e2b;
		repeat (16) @(negedge clk_sys);
		resetd = 1'b0;

		// Reset values
		repeat (2) @(negedge clk_sys);
		check_value("reset_led", 16'h0000, 16'(led));
		check_value("reset_sync", 16'h0000, 16'(dut_sync));
		check_value("reset_pins", 16'h0000, 16'({vsync_pin, hsync_pin}));

		video_on = 1'b1;
		chk_raw  = 1'b1;
		wait_frames(1);

		// All four polarity pairs in Gray order
		for (int p = 0; p < 4; p++) begin
			inv = video_sync_pkg::sync_pair_t'(2'(p ^ (p >> 1)));
			wait_frames(2);
			chk_sync = 1'b1;
			wait_frames(1);
			chk_sync = 1'b0;
		end

		// LED status, then host overtake
		check_value("led_status", 16'(ref_led('0, inv)), 16'(led));
		draw_bits(cmd_lfsr, 16, bits);
		led_word = hps_io_pkg::led_ctrl_t'(bits);
		host_cmd(hps_io_pkg::CMD_LED, 1, led_word, '0);
		check_value("led_write", 16'(ref_led(led_word, inv)), 16'(led));
		repeat (20) @(negedge clk_sys);
		check_value("led_hold", 16'(ref_led(led_word, inv)), 16'(led));

		// Composite sync off
		draw_bits(cmd_lfsr, 16, bits);
		bits[hps_io_pkg::CFG_CSYNC_BIT] = 1'b0;
		host_cmd(hps_io_pkg::CMD_CFG, 1, bits, '0);
		wait_frames(1);

		// Composite sync on
		chk_raw = 1'b0;
		draw_bits(cmd_lfsr, 16, bits);
		bits[hps_io_pkg::CFG_CSYNC_BIT] = 1'b1;
		host_cmd(hps_io_pkg::CMD_CFG, 1, bits, '0);
		repeat (4) @(negedge clk_sys);
		chk_cs = 1'b1;
		wait_frames(2);
		chk_cs = 1'b0;
		host_cmd(hps_io_pkg::CMD_CFG, 1, 16'h0000, '0);
		repeat (4) @(negedge clk_sys);
		chk_raw = 1'b1;

		// Unknown opcode swallows its words
		host_cmd(8'h7e, 2, 16'hffff, 16'h5aa5);
		check_value("unknown_op", 16'(ref_led(led_word, inv)), 16'(led));
		// Opcode alone, then a fresh LED command
		host_cmd(hps_io_pkg::CMD_CFG, 0, '0, '0);
		draw_bits(cmd_lfsr, 16, bits);
		led_word = hps_io_pkg::led_ctrl_t'(bits);
		host_cmd(hps_io_pkg::CMD_LED, 1, led_word, '0);
		check_value("led_reframe", 16'(ref_led(led_word, inv)), 16'(led));
		wait_frames(1);
		chk_raw = 1'b0;

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire
